//--- files.f
ladybird_pkg.sv
uart_rx.sv
uart_tx.sv
serial_bridge.sv
button_logger.sv
bus_arbiter.sv
data_ram.sv
ladybird_top.sv
tb_ladybird.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_ladybird -o tb_ladybird \
  && ./obj_dir/tb_ladybird > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb_ladybird.sv
`timescale 1ns/1ps

module tb_ladybird;

  localparam int N_BTN      = ladybird_pkg::N_BTN;
  localparam int BIT_CYCLES = ladybird_pkg::BAUD_DIV;
  // Upper bound on frames sent or received over the whole run
  localparam int N_FRAMES    = 100;
  localparam int CYCLE_LIMIT = N_FRAMES * 60 * BIT_CYCLES + 20000;
  // Line time of a six-byte write frame
  localparam int WRITE_CYCLES  = 6 * 10 * BIT_CYCLES;
  localparam int CONTEND_FIRST = WRITE_CYCLES - 11;

  logic             clk_i;
  logic             anrst_i;
  logic             uart_rx_i;
  logic             uart_tx_o;
  logic [N_BTN-1:0] btn_i;
  logic [N_BTN-1:0] led_o;

  logic [31:0]      model_mem [256];
  int               model_count;
  logic [N_BTN-1:0] model_logged;
  logic [31:0]      lfsr_q;
  logic [7:0]       addr_q [$];
  logic [31:0]      exp_q [$];
  string            name_q [$];
  int               reads_issued;
  int               reads_done;
  int               cycle_cnt;

  ladybird_top DUT (
    .clk_i     (clk_i),
    .anrst_i   (anrst_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .btn_i     (btn_i),
    .led_o     (led_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = next_lfsr(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [7:0] rand_addr();
    logic [31:0] v;
    v = rand_bits(8);
    while (v[7:0] >= ladybird_pkg::LOG_BASE) begin
      v = rand_bits(8);
    end
    return v[7:0];
  endfunction

  function automatic logic [31:0] record_word(input int count, input logic [N_BTN-1:0] btn);
    logic [31:0] w;
    w = '0;
    w[31:16] = count[15:0];
    w[N_BTN-1:0] = btn;
    return w;
  endfunction

  function automatic void store_word(input logic [7:0] a, input logic [31:0] d);
    model_mem[a] = d;
  endfunction

  // Only a value that differs from the last logged one makes a record
  function automatic void log_event(input logic [N_BTN-1:0] btn);
    int idx;
    idx = model_count % ladybird_pkg::LOG_DEPTH;
    if (btn != model_logged) begin
      model_mem[ladybird_pkg::LOG_BASE + idx[7:0]] = record_word(model_count, btn);
      model_count++;
      model_logged = btn;
    end
  endfunction

  function automatic logic [31:0] expected_word(input logic [7:0] a);
    return model_mem[a];
  endfunction

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_fail($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk_i);
      uart_rx_i <= frame[i];
      repeat (BIT_CYCLES - 1) @(posedge clk_i);
    end
  endtask

  task automatic receive_byte(output logic [7:0] b);
    int i;
    b = '0;
    while (uart_tx_o !== 1'b0) @(negedge clk_i);
    repeat (BIT_CYCLES / 2) @(negedge clk_i);
    if (uart_tx_o !== 1'b0) begin
      stop_with_fail("reply start bit ended early");
    end
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge clk_i);
      b[i] = uart_tx_o;
    end
    repeat (BIT_CYCLES) @(negedge clk_i);
    if (uart_tx_o !== 1'b1) begin
      stop_with_fail("reply stop bit was not high");
    end
  endtask

  task automatic write_frame(input logic [7:0] a, input logic [31:0] d);
    int i;
    store_word(a, d);
    send_byte(ladybird_pkg::CMD_WRITE);
    send_byte(a);
    for (i = 0; i < 4; i++) begin
      send_byte(d[8*i +: 8]);
    end
    repeat (2 * BIT_CYCLES) @(posedge clk_i);
  endtask

  task automatic read_frame(input string name, input logic [7:0] a);
    int target;
    reads_issued++;
    target = reads_issued;
    exp_q.push_back(expected_word(a));
    name_q.push_back(name);
    send_byte(ladybird_pkg::CMD_READ);
    send_byte(a);
    while (reads_done < target) @(posedge clk_i);
    repeat (2 * BIT_CYCLES) @(posedge clk_i);
  endtask

  task automatic change_buttons();
    logic [31:0]      v;
    logic [N_BTN-1:0] flip;
    logic [N_BTN-1:0] next;
    v = rand_bits(N_BTN);
    flip = v[N_BTN-1:0];
    if (flip == '0) begin
      flip[0] = 1'b1;
    end
    next = btn_i ^ flip;
    @(posedge clk_i);
    btn_i <= next;
    log_event(next);
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check_value("led", 32'(next), 32'(led_o));
  endtask

  task automatic check_ring(input string tag);
    int i;
    for (i = 0; i < ladybird_pkg::LOG_DEPTH; i++) begin
      if (i < model_count) begin
        read_frame($sformatf("%s slot %0d", tag, i), ladybird_pkg::LOG_BASE + i[7:0]);
      end
    end
  endtask

  // Collects four reply bytes into a word and compares it
  initial begin : reply_check
    logic [7:0]  b;
    logic [31:0] word;
    int          k;
    word = '0;
    @(posedge anrst_i);
    forever begin
      for (k = 0; k < 4; k++) begin
        receive_byte(b);
        word = {b, word[31:8]};
      end
      if (exp_q.size() == 0) begin
        stop_with_fail("a reply arrived with no read pending");
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(), word);
        reads_done++;
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    stop_with_fail($sformatf("timeout: no result after %0d clock cycles", CYCLE_LIMIT));
  end

  initial begin : stimulus
    int          i;
    int          idx;
    logic [7:0]  a;
    logic [31:0] d;
    anrst_i      <= 1'b0;
    uart_rx_i    <= 1'b1;
    btn_i        <= '0;
    lfsr_q       = 32'h5773_a96a;
    model_count  = 0;
    model_logged = '0;
    reads_issued = 0;
    reads_done   = 0;
    repeat (5) @(posedge clk_i);
    anrst_i <= 1'b1;
    repeat (4) @(posedge clk_i);

    for (i = 0; i < 20; i++) begin
      a = rand_addr();
      d = rand_bits(32);
      addr_q.push_back(a);
      write_frame(a, d);
    end
    for (i = 0; i < 20; i++) begin
      read_frame($sformatf("word %0d", i), addr_q[i]);
    end

    for (i = 0; i < 6; i++) begin
      change_buttons();
      idx = (model_count - 1) % ladybird_pkg::LOG_DEPTH;
      read_frame($sformatf("log event %0d", model_count - 1),
                 ladybird_pkg::LOG_BASE + idx[7:0]);
    end

    // Button changes step one cycle at a time across the end of a write frame
    // so that one of them meets the bridge request in the same cycle
    for (i = 0; i < 8; i++) begin
      a = rand_addr();
      d = rand_bits(32);
      addr_q.push_back(a);
      fork
        write_frame(a, d);
        begin
          repeat (CONTEND_FIRST + i) @(posedge clk_i);
          change_buttons();
        end
      join
    end
    for (i = 20; i < 28; i++) begin
      read_frame($sformatf("contention word %0d", i), addr_q[i]);
    end
    check_ring("ring");

    send_byte(8'hA5);
    send_byte(8'h3C);
    send_byte(8'h0F);
    repeat (2 * BIT_CYCLES) @(posedge clk_i);
    read_frame("after unknown command", addr_q[0]);

    // Enough events to wrap the ring
    for (i = 0; i < 20; i++) begin
      change_buttons();
      repeat (20) @(posedge clk_i);
    end
    check_ring("wrapped ring");

    if (exp_q.size() != 0) begin
      stop_with_fail("read replies were still outstanding at the end");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- ladybird_top.sv
`timescale 1ns/1ps

module ladybird_top (
  input  logic                              clk_i,
  input  logic                              anrst_i,
  input  logic                              uart_rx_i,
  output logic                              uart_tx_o,
  input  logic [ladybird_pkg::N_BTN-1:0]    btn_i,
  output logic [ladybird_pkg::N_BTN-1:0]    led_o
);

  logic [7:0]                                rx_data;
  logic                                      rx_valid;
  logic [7:0]                                tx_data;
  logic                                      tx_start;
  logic                                      tx_busy;

  logic [ladybird_pkg::N_MASTERS-1:0]        m_req;
  logic [ladybird_pkg::N_MASTERS-1:0]        m_gnt;
  logic [ladybird_pkg::N_MASTERS-1:0]        m_rvalid;
  logic                                      bridge_we;
  logic [ladybird_pkg::ADDR_W-1:0]           m_addr [ladybird_pkg::N_MASTERS];
  logic [ladybird_pkg::XLEN-1:0]             m_wdata [ladybird_pkg::N_MASTERS];
  logic [ladybird_pkg::XLEN-1:0]             bus_rdata;

  logic                                      ram_en;
  logic                                      ram_we;
  logic [ladybird_pkg::ADDR_W-1:0]           ram_addr;
  logic [ladybird_pkg::XLEN-1:0]             ram_wdata;
  logic [ladybird_pkg::XLEN-1:0]             ram_rdata;

  uart_rx u_uart_rx (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .rx_i    (uart_rx_i),
    .data_o  (rx_data),
    .valid_o (rx_valid)
  );

  uart_tx u_uart_tx (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .data_i  (tx_data),
    .start_i (tx_start),
    .tx_o    (uart_tx_o),
    .busy_o  (tx_busy)
  );

  serial_bridge u_bridge (
    .clk_i      (clk_i),
    .anrst_i    (anrst_i),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .tx_busy_i  (tx_busy),
    .gnt_i      (m_gnt[0]),
    .rvalid_i   (m_rvalid[0]),
    .rdata_i    (bus_rdata),
    .tx_data_o  (tx_data),
    .tx_start_o (tx_start),
    .req_o      (m_req[0]),
    .we_o       (bridge_we),
    .addr_o     (m_addr[0]),
    .wdata_o    (m_wdata[0])
  );

  button_logger u_logger (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .btn_i   (btn_i),
    .gnt_i   (m_gnt[1]),
    .led_o   (led_o),
    .req_o   (m_req[1]),
    .addr_o  (m_addr[1]),
    .wdata_o (m_wdata[1])
  );

  // Logger only ever writes
  bus_arbiter u_arbiter (
    .clk_i       (clk_i),
    .anrst_i     (anrst_i),
    .req_i       (m_req),
    .we_i        ({1'b1, bridge_we}),
    .addr_i      (m_addr),
    .wdata_i     (m_wdata),
    .ram_rdata_i (ram_rdata),
    .gnt_o       (m_gnt),
    .rvalid_o    (m_rvalid),
    .rdata_o     (bus_rdata),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata)
  );

  data_ram u_ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic                              clk_i,
  input  logic                              en_i,
  input  logic                              we_i,
  input  logic [ladybird_pkg::ADDR_W-1:0]   addr_i,
  input  logic [ladybird_pkg::XLEN-1:0]     wdata_i,
  output logic [ladybird_pkg::XLEN-1:0]     rdata_o
);

  logic [ladybird_pkg::XLEN-1:0] mem [ladybird_pkg::N_WORDS];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];
    end
  end

  a_addr_known: assert property (
    @(posedge clk_i)
    en_i |-> !$isunknown(addr_i)
  );

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                                clk_i,
  input  logic                                anrst_i,
  input  logic [ladybird_pkg::N_MASTERS-1:0]  req_i,
  input  logic [ladybird_pkg::N_MASTERS-1:0]  we_i,
  input  logic [ladybird_pkg::ADDR_W-1:0]     addr_i [ladybird_pkg::N_MASTERS],
  input  logic [ladybird_pkg::XLEN-1:0]       wdata_i [ladybird_pkg::N_MASTERS],
  input  logic [ladybird_pkg::XLEN-1:0]       ram_rdata_i,
  output logic [ladybird_pkg::N_MASTERS-1:0]  gnt_o,
  output logic [ladybird_pkg::N_MASTERS-1:0]  rvalid_o,
  output logic [ladybird_pkg::XLEN-1:0]       rdata_o,
  output logic                                ram_en_o,
  output logic                                ram_we_o,
  output logic [ladybird_pkg::ADDR_W-1:0]     ram_addr_o,
  output logic [ladybird_pkg::XLEN-1:0]       ram_wdata_o
);

  logic win;
  logic last_q;

  // Tie goes to whoever did not win last time
  always_comb begin
    if (req_i[0] && req_i[1]) begin
      win = ~last_q;
    end else begin
      win = req_i[1];
    end
  end

  assign ram_en_o = |req_i;

  always_comb begin
    gnt_o = '0;
    if (ram_en_o) begin
      gnt_o[win] = 1'b1;
    end
  end

  assign ram_we_o    = ram_en_o & we_i[win];
  assign ram_addr_o  = addr_i[win];
  assign ram_wdata_o = wdata_i[win];

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (~anrst_i) begin
      last_q   <= 1'b1;
      rvalid_o <= '0;
    end else begin
      if (ram_en_o) begin
        last_q <= win;
      end
      // Read data lands with the RAM's one-cycle latency
      rvalid_o <= gnt_o & ~we_i;
    end
  end

  assign rdata_o = ram_rdata_i;

  // No master is kept waiting two cycles in a row
  a_wait_one_cycle: assert property (
    @(posedge clk_i) disable iff (~anrst_i)
    (req_i & ~gnt_o) != '0 |=> (req_i & ~gnt_o & $past(req_i & ~gnt_o)) == '0
  );

  a_gnt_to_requester: assert property (
    @(posedge clk_i) disable iff (~anrst_i)
    (gnt_o & ~req_i) == '0
  );

endmodule

//--- button_logger.sv
`timescale 1ns/1ps

module button_logger (
  input  logic                              clk_i,
  input  logic                              anrst_i,
  input  logic [ladybird_pkg::N_BTN-1:0]    btn_i,
  input  logic                              gnt_i,
  output logic [ladybird_pkg::N_BTN-1:0]    led_o,
  output logic                              req_o,
  output logic [ladybird_pkg::ADDR_W-1:0]   addr_o,
  output logic [ladybird_pkg::XLEN-1:0]     wdata_o
);

  logic [ladybird_pkg::N_BTN-1:0]   btn_meta_q;
  logic [ladybird_pkg::N_BTN-1:0]   btn_sync_q;
  logic [ladybird_pkg::N_BTN-1:0]   logged_q;
  logic [ladybird_pkg::N_BTN-1:0]   snap_q;
  logic [ladybird_pkg::EVT_W-1:0]   count_q;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (~anrst_i) begin
      btn_meta_q <= '0;
      btn_sync_q <= '0;
      led_o      <= '0;
      logged_q   <= '0;
      snap_q     <= '0;
      count_q    <= '0;
      req_o      <= 1'b0;
    end else begin
      btn_meta_q <= btn_i;
      btn_sync_q <= btn_meta_q;
      led_o      <= btn_sync_q;
      if (req_o) begin
        if (gnt_i) begin
          req_o    <= 1'b0;
          logged_q <= snap_q;
          count_q  <= count_q + 1'b1;
        end
      end else if (btn_sync_q != logged_q) begin
        // Freeze the value so the record stays steady until granted
        req_o  <= 1'b1;
        snap_q <= btn_sync_q;
      end
    end
  end

  // Slot is the event count modulo the ring depth
  assign addr_o = ladybird_pkg::LOG_BASE +
                  {{(ladybird_pkg::ADDR_W - ladybird_pkg::LOG_IDX_W){1'b0}},
                   count_q[ladybird_pkg::LOG_IDX_W-1:0]};

  assign wdata_o = {count_q,
                    {(ladybird_pkg::XLEN - ladybird_pkg::EVT_W - ladybird_pkg::N_BTN){1'b0}},
                    snap_q};

endmodule

//--- serial_bridge.sv
`timescale 1ns/1ps

module serial_bridge (
  input  logic                              clk_i,
  input  logic                              anrst_i,
  input  logic [7:0]                        rx_data_i,
  input  logic                              rx_valid_i,
  input  logic                              tx_busy_i,
  input  logic                              gnt_i,
  input  logic                              rvalid_i,
  input  logic [ladybird_pkg::XLEN-1:0]     rdata_i,
  output logic [7:0]                        tx_data_o,
  output logic                              tx_start_o,
  output logic                              req_o,
  output logic                              we_o,
  output logic [ladybird_pkg::ADDR_W-1:0]   addr_o,
  output logic [ladybird_pkg::XLEN-1:0]     wdata_o
);

  typedef enum logic [2:0] {
    BR_IDLE,
    BR_ADDR,
    BR_DATA,
    BR_BUS,
    BR_RDWAIT,
    BR_SEND,
    BR_HOLD
  } br_state_t;

  br_state_t                        state_q;
  logic [1:0]                       byte_q;
  logic [ladybird_pkg::XLEN-1:0]    reply_q;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (~anrst_i) begin
      state_q    <= BR_IDLE;
      byte_q     <= '0;
      we_o       <= 1'b0;
      req_o      <= 1'b0;
      tx_start_o <= 1'b0;
    end else begin
      tx_start_o <= 1'b0;
      case (state_q)
        BR_IDLE: begin
          if (rx_valid_i) begin
            if (rx_data_i == ladybird_pkg::CMD_WRITE) begin
              we_o    <= 1'b1;
              state_q <= BR_ADDR;
            end else if (rx_data_i == ladybird_pkg::CMD_READ) begin
              we_o    <= 1'b0;
              state_q <= BR_ADDR;
            end
          end
        end
        BR_ADDR: begin
          if (rx_valid_i) begin
            byte_q <= '0;
            if (we_o) begin
              state_q <= BR_DATA;
            end else begin
              req_o   <= 1'b1;
              state_q <= BR_BUS;
            end
          end
        end
        BR_DATA: begin
          if (rx_valid_i) begin
            byte_q <= byte_q + 1'b1;
            if (byte_q == 2'd3) begin
              req_o   <= 1'b1;
              state_q <= BR_BUS;
            end
          end
        end
        BR_BUS: begin
          if (gnt_i) begin
            req_o   <= 1'b0;
            state_q <= we_o ? BR_IDLE : BR_RDWAIT;
          end
        end
        BR_RDWAIT: begin
          // First reply byte goes out right away
          if (rvalid_i) begin
            tx_start_o <= 1'b1;
            byte_q     <= '0;
            state_q    <= BR_HOLD;
          end
        end
        BR_SEND: begin
          if (~tx_busy_i) begin
            tx_start_o <= 1'b1;
            state_q    <= BR_HOLD;
          end
        end
        default: begin
          // Busy shows one cycle after the start pulse
          if (tx_busy_i) begin
            byte_q  <= byte_q + 1'b1;
            state_q <= (byte_q == 2'd3) ? BR_IDLE : BR_SEND;
          end
        end
      endcase
    end
  end

  // Payload bytes arrive little-endian
  always_ff @(posedge clk_i) begin
    if (rx_valid_i && state_q == BR_ADDR) begin
      addr_o <= rx_data_i;
    end
    if (rx_valid_i && state_q == BR_DATA) begin
      wdata_o <= {rx_data_i, wdata_o[ladybird_pkg::XLEN-1:8]};
    end
    if (state_q == BR_RDWAIT && rvalid_i) begin
      reply_q <= rdata_i;
    end else if (state_q == BR_HOLD && tx_busy_i) begin
      reply_q <= {8'h00, reply_q[ladybird_pkg::XLEN-1:8]};
    end
  end

  assign tx_data_o = reply_q[7:0];

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk_i,
  input  logic       anrst_i,
  input  logic [7:0] data_i,
  input  logic       start_i,
  output logic       tx_o,
  output logic       busy_o
);

  logic [9:0]                           frame_q;
  logic [ladybird_pkg::BAUD_CNT_W-1:0]  cnt_q;
  logic [3:0]                           bit_q;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (~anrst_i) begin
      busy_o <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else begin
      if (~busy_o) begin
        if (start_i) begin
          busy_o <= 1'b1;
          cnt_q  <= '0;
          bit_q  <= '0;
        end
      end else if (cnt_q == ladybird_pkg::BAUD_LAST) begin
        cnt_q <= '0;
        bit_q <= bit_q + 1'b1;
        // Stop bit done
        if (bit_q == 4'd9) begin
          busy_o <= 1'b0;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Start bit sits in bit 0 and the frame shifts right
  always_ff @(posedge clk_i) begin
    if (~busy_o && start_i) begin
      frame_q <= {1'b1, data_i, 1'b0};
    end else if (busy_o && cnt_q == ladybird_pkg::BAUD_LAST) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  assign tx_o = busy_o ? frame_q[0] : 1'b1;

  // Bridge must wait out the whole frame before the next byte
  a_no_start_when_busy: assert property (
    @(posedge clk_i) disable iff (~anrst_i)
    $rose(start_i) |-> ~busy_o
  );

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk_i,
  input  logic       anrst_i,
  input  logic       rx_i,
  output logic [7:0] data_o,
  output logic       valid_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t                            state_q;
  logic                                 rx_meta_q;
  logic                                 rx_sync_q;
  logic [ladybird_pkg::BAUD_CNT_W-1:0]  cnt_q;
  logic [2:0]                           bit_q;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (~anrst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_q     <= '0;
      valid_o   <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      valid_o   <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (~rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Recheck the line half a bit in so a short glitch is not a start
          if (cnt_q == ladybird_pkg::BAUD_HALF) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == ladybird_pkg::BAUD_LAST) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (cnt_q == ladybird_pkg::BAUD_LAST) begin
            // Framing error drops the byte
            valid_o <= rx_sync_q;
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && cnt_q == ladybird_pkg::BAUD_LAST) begin
      data_o <= {rx_sync_q, data_o[7:1]};
    end
  end

endmodule

//--- ladybird_pkg.sv
package ladybird_pkg;

  // Bus geometry
  localparam int XLEN    = 32;
  localparam int ADDR_W  = 8;
  localparam int N_WORDS = 2 ** ADDR_W;

  // Button log ring at the top of memory
  localparam logic [ADDR_W-1:0] LOG_BASE = 8'hF0;
  localparam int LOG_DEPTH = 16;
  localparam int LOG_IDX_W = $clog2(LOG_DEPTH);
  localparam int EVT_W     = 16;

  // UART bit timing kept small for simulation
  localparam int BAUD_DIV   = 16;
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(BAUD_DIV - 1);
  localparam logic [BAUD_CNT_W-1:0] BAUD_HALF = BAUD_CNT_W'(BAUD_DIV / 2 - 1);

  // Host command bytes
  localparam logic [7:0] CMD_WRITE = 8'h57;
  localparam logic [7:0] CMD_READ  = 8'h52;

  localparam int N_BTN = 4;

  // Master 0 is the serial bridge, master 1 the button logger
  localparam int N_MASTERS = 2;

endpackage
